//--- Makefile
# Verilator build and run of the hub register block testbench

TOP = tb_hub_reg

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

//--- hdl/hub_bcast_trig.sv
`timescale 1ns/1ps
// ------------------------------
// broadcast trigger
// waits one slot per lower-numbered board plus the acknowledge time,
// then asks the link layer to broadcast this board's entry
// ------------------------------
module hub_bcast_trig
    import hub_pkg::*;
(
    input  logic        sysclk,
    input  logic        write_trig_reset,
    input  logic        query_wen,
    input  logic [15:0] board_mask_lower,
    input  logic        board_selected,
    output logic        write_trig
);

    logic [15:0] lower_q;
    // number of selected boards below this one
    logic [4:0]  lower_cnt;
    logic [12:0] trig_count;
    logic [12:0] counter;
    trig_state_e state;

    // ------------------------------
    // popcount pipeline
    // ------------------------------
    // two register stages, the count settles long before the counter
    // can reach even the shortest wait of ack_cycles
    always_ff @(posedge sysclk) begin
        lower_q   <= board_mask_lower;
        lower_cnt <= 5'($countones(lower_q));
    end

    assign trig_count = 13'(lower_cnt) * 13'(slot_cycles) + 13'(ack_cycles);

    // ------------------------------
    // trigger FSM
    // ------------------------------
    // the compare hit moves to trig_fire and write_trig follows one edge
    // later, so it rises slot_cycles*k + ack_cycles + 2 after the query
    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            state      <= trig_idle;
            counter    <= '0;
            write_trig <= 1'b0;
        end else if (query_wen) begin
            // every query restarts the wait and drops an earlier trigger
            state      <= trig_wait;
            counter    <= '0;
            write_trig <= 1'b0;
        end else begin
            case (state)
                trig_wait: begin
                    if (counter == trig_count) begin
                        state <= trig_fire;
                    end else begin
                        counter <= counter + 13'd1;
                    end
                end
                trig_fire: begin
                    // a board outside the mask keeps quiet
                    write_trig <= board_selected;
                    state      <= trig_done;
                end
                // idle and done hold until the next query
                default: begin
                    state <= state;
                end
            endcase
        end
    end

endmodule

//--- hdl/hub_mem.sv
`timescale 1ns/1ps
// ------------------------------
// hub memory
// 512 x 32 dual-port RAM, one write port and one registered read port
// ------------------------------
module hub_mem (
    input  logic        sysclk,
    input  logic        mem_wen,
    input  logic [8:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [8:0]  raddr,
    output logic [31:0] rdata
);

    // one 32-quadlet slot per board, each holding a 29-quadlet entry
    logic [31:0] mem [0:511];

    // write port, peer boards fill their entries here
    always_ff @(posedge sysclk) begin
        if (mem_wen) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, data appears one cycle after the address
    always_ff @(posedge sysclk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- hdl/hub_pkg.sv
// ------------------------------
// hub register block definitions
// address map, entry sizes, register selects and the bundles
// shared between the hub blocks
// ------------------------------
package hub_pkg;

    // ------------------------------
    // address map and sizes
    // ------------------------------

    // upper address nibble of the whole hub space
    localparam logic [3:0] addr_hub = 4'h1;
    // word index of the hub registers, which places them at 0x1800 to 0x1803
    localparam logic [9:0] hub_reg_base = 10'h200;
    // quadlets written by one board into its entry
    localparam logic [8:0] num_quads = 9'd29;
    // distance from the end of one entry to the start of the next 32-quadlet slot
    localparam logic [8:0] quad_offset = 9'd3;
    // boards on the bus, so board numbers are 4 bits wide
    localparam int num_boards = 16;
    // clock cycles given to each lower-numbered board for its broadcast
    localparam int slot_cycles = 256;
    // extra cycles reserved for the acknowledge packet
    localparam int ack_cycles = 150;

    // ------------------------------
    // enums
    // ------------------------------

    // hub register picked by the low two address bits
    typedef enum logic [1:0] {
        sel_seq_mask = 2'd0,
        sel_index_lo = 2'd1,
        sel_index_hi = 2'd2,
        sel_lower    = 2'd3
    } hub_sel_e;

    // broadcast trigger FSM
    typedef enum logic [1:0] {
        trig_idle = 2'd0,
        trig_wait = 2'd1,
        trig_fire = 2'd2,
        trig_done = 2'd3
    } trig_state_e;

    // ------------------------------
    // bundles
    // ------------------------------

    // one write request as it arrives from the link layer
    typedef struct packed {
        logic        wen;
        logic [15:0] waddr;
        logic [31:0] wdata;
    } hub_wr_t;

    // latched query, the lower mask only holds boards below this one
    typedef struct packed {
        logic [15:0] seq_num;
        logic [15:0] board_mask;
        logic [15:0] board_mask_lower;
    } hub_query_t;

    // ordered read list, entry 0 sits in the low nibble
    typedef logic [num_boards-1:0][3:0] read_list_t;

endpackage

//--- hdl/hub_query_regs.sv
`timescale 1ns/1ps
// ------------------------------
// hub query registers
// latches the query, builds the ordered read list, tracks which
// boards have written since the query and runs the broadcast timer
// ------------------------------
module hub_query_regs
    import hub_pkg::*;
(
    input  logic                  sysclk,
    input  logic                  write_trig_reset,
    input  logic                  query_wen,
    input  hub_wr_t               wr,
    input  logic                  mem_wen,
    input  logic [3:0]            board_id,
    output hub_query_t            query,
    output read_list_t            read_list,
    output logic [num_boards-1:0] board_updated,
    output logic [13:0]           bc_timer
);

    logic [15:0] seq_num;
    logic [15:0] board_mask;
    // mask for which the read list is complete
    logic [15:0] last_mask;
    // next free read list slot and the board number under test
    logic [3:0]  cur_index;
    logic [3:0]  cur_board;
    logic [15:0] lower_sel;
    logic        new_mask;

    // all board numbers below this board
    assign lower_sel = (16'd1 << board_id) - 16'd1;

    assign query = '{
        seq_num:          seq_num,
        board_mask:       board_mask,
        board_mask_lower: lower_sel & board_mask
    };

    // a zero mask would leave the builder without any board to find
    assign new_mask = query_wen && (wr.wdata[15:0] != 16'd0);

    // ------------------------------
    // query latch, timer and update tracking
    // ------------------------------
    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            seq_num       <= '0;
            board_mask    <= '0;
            board_updated <= '0;
            bc_timer      <= '0;
        end else begin
            // the timer runs freely and counts from the last query
            bc_timer <= bc_timer + 14'd1;
            if (query_wen) begin
                seq_num       <= wr.wdata[31:16];
                bc_timer      <= '0;
                board_updated <= '0;
            end
            if (new_mask) begin
                board_mask <= wr.wdata[15:0];
            end
            // a peer write anywhere in its 32-quadlet slot marks that board,
            // and it wins over the clear of a query in the same cycle
            if (mem_wen) begin
                board_updated[wr.waddr[8:5]] <= 1'b1;
            end
        end
    end

    // ------------------------------
    // read list builder
    // ------------------------------
    // one board number is tested per cycle, and each selected board is
    // stored in the next slot, the walk wraps around the board numbers
    // until slot 15 is filled so the list repeats the selected boards
    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            last_mask <= '0;
            cur_index <= '0;
            cur_board <= '0;
            read_list <= '0;
        end else if (new_mask) begin
            // clearing last_mask forces a fresh pass for any non-zero mask
            last_mask <= '0;
            cur_index <= '0;
            cur_board <= '0;
        end else if (board_mask != last_mask) begin
            if (board_mask[cur_board]) begin
                read_list[cur_index] <= cur_board;
                cur_index            <= cur_index + 4'd1;
                if (cur_index == 4'hf) begin
                    last_mask <= board_mask;
                end
            end
            cur_board <= cur_board + 4'd1;
        end
    end

endmodule

//--- hdl/hub_read_xlate.sv
`timescale 1ns/1ps
// ------------------------------
// hub read address translation
// maps back-to-back host reads onto the 29-quadlet entries of the
// boards in the read list and spots the trailing timing quadlet
// ------------------------------
module hub_read_xlate
    import hub_pkg::*;
(
    input  logic        sysclk,
    input  logic        write_trig_reset,
    input  logic        query_wen,
    input  logic [15:0] reg_raddr,
    input  read_list_t  read_list,
    input  logic [13:0] bc_timer,
    output logic [8:0]  mem_raddr,
    output logic [3:0]  read_board,
    output logic        is_extra,
    output logic [13:0] bc_read_start
);

    // next entry boundary in host addresses (29, 58, 87 and so on)
    logic [8:0] mult_nq;
    // quadlets skipped so far, grows by 3 per finished entry
    logic [8:0] offset;
    logic       mem_space;
    logic       at_start;
    logic       at_boundary;
    logic [8:0] addr_add;
    logic [8:0] raddr_off;

    // the hub memory occupies 0x1000 to 0x11ff
    assign mem_space   = (reg_raddr[15:12] == addr_hub) && (reg_raddr[11:9] == 3'd0);
    assign at_start    = mem_space && (reg_raddr[8:0] == 9'd0);
    assign at_boundary = mem_space && (reg_raddr[8:0] == mult_nq);

    // ------------------------------
    // translation state
    // ------------------------------
    // a read of address 0 restarts the sweep, so the host can read the
    // hub again after one query, a partial read may continue from where
    // the previous one stopped as long as the addresses stay contiguous
    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            mult_nq       <= num_quads;
            offset        <= '0;
            bc_read_start <= '0;
        end else if (query_wen || at_start) begin
            mult_nq <= num_quads;
            offset  <= '0;
            // remember when the host started reading, relative to the query
            if (!query_wen) begin
                bc_read_start <= bc_timer;
            end
        end else if (at_boundary) begin
            mult_nq <= mult_nq + num_quads;
            offset  <= offset + quad_offset;
        end
    end

    // the state only moves on the boundary edge, so the boundary read
    // itself adds the gap here, and a restart at 0 ignores the old offset
    always_comb begin
        if (at_start) begin
            addr_add = 9'd0;
        end else if (at_boundary) begin
            addr_add = offset + quad_offset;
        end else begin
            addr_add = offset;
        end
    end

    assign raddr_off = reg_raddr[8:0] + addr_add;

    // bits 8:5 pick the list slot, the low bits the quadlet in the entry
    assign read_board = read_list[raddr_off[8:5]];
    assign mem_raddr  = {read_board, raddr_off[4:0]};

    // once the list wraps back to its first board, every entry has been
    // read and the next quadlet carries the timing information
    assign is_extra = (addr_add != 9'd0) && (read_board == read_list[0]);

endmodule

//--- hdl/hub_reg.sv
`timescale 1ns/1ps
// ------------------------------
// hub register block
// decodes the hub space, stamps first-quadlet writes with the timer
// and selects the read data for registers and hub memory
// ------------------------------
module hub_reg
    import hub_pkg::*;
(
    input  logic        sysclk,
    input  logic        write_trig_reset,
    input  logic        reg_wen,
    input  logic [15:0] reg_waddr,
    input  logic [31:0] reg_wdata,
    input  logic [15:0] reg_raddr,
    input  logic [3:0]  board_id,
    output logic [31:0] reg_rdata,
    output logic [15:0] seq_num,
    output logic [15:0] board_mask,
    output logic        hub_reg_wen,
    output logic        write_trig,
    output logic        updated
);

    hub_wr_t               wr;
    hub_query_t            query;
    read_list_t            read_list;
    hub_sel_e              rd_sel;
    logic                  query_wen;
    logic                  mem_wen;
    logic [31:0]           mem_wdata;
    logic [num_boards-1:0] board_updated;
    logic [13:0]           bc_timer;
    logic [13:0]           bc_read_start;
    logic [8:0]            mem_raddr;
    logic [31:0]           mem_rdata;
    logic [3:0]            read_board;
    logic                  is_extra;
    logic                  hub_reg_raddr;
    logic                  mem_rd;
    logic [31:0]           reg_data;
    logic [31:0]           hub_data;
    // read selects delayed to line up with the registered memory data
    logic                  mem_rd_q;
    logic                  extra_q;
    logic                  first_q;
    logic [3:0]            board_q;

    assign wr = '{wen: reg_wen, waddr: reg_waddr, wdata: reg_wdata};

    // ------------------------------
    // write decode
    // ------------------------------
    // only 0x1800 is writable among the hub registers
    assign query_wen   = wr.wen && (wr.waddr[15:12] == addr_hub)
                         && (wr.waddr[11:2] == hub_reg_base) && (wr.waddr[1:0] == 2'd0);
    assign mem_wen     = wr.wen && (wr.waddr[15:12] == addr_hub) && (wr.waddr[11:9] == 3'd0);
    assign hub_reg_wen = query_wen;

    // the first quadlet keeps its upper half, bit 15 flags an update and
    // bits 13:0 record when the board wrote, relative to the query
    assign mem_wdata = (wr.waddr[4:0] == 5'd0) ? {wr.wdata[31:16], 2'b10, bc_timer}
                                               : wr.wdata;

    hub_query_regs hub_query_regs_inst (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .query_wen        (query_wen),
        .wr               (wr),
        .mem_wen          (mem_wen),
        .board_id         (board_id),
        .query            (query),
        .read_list        (read_list),
        .board_updated    (board_updated),
        .bc_timer         (bc_timer)
    );

    hub_read_xlate hub_read_xlate_inst (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .query_wen        (query_wen),
        .reg_raddr        (reg_raddr),
        .read_list        (read_list),
        .bc_timer         (bc_timer),
        .mem_raddr        (mem_raddr),
        .read_board       (read_board),
        .is_extra         (is_extra),
        .bc_read_start    (bc_read_start)
    );

    hub_mem hub_mem_inst (
        .sysclk  (sysclk),
        .mem_wen (mem_wen),
        .waddr   (wr.waddr[8:0]),
        .wdata   (mem_wdata),
        .raddr   (mem_raddr),
        .rdata   (mem_rdata)
    );

    hub_bcast_trig hub_bcast_trig_inst (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .query_wen        (query_wen),
        .board_mask_lower (query.board_mask_lower),
        .board_selected   (query.board_mask[board_id]),
        .write_trig       (write_trig)
    );

    assign seq_num    = query.seq_num;
    assign board_mask = query.board_mask;
    // zero mask after reset counts as fully updated
    assign updated    = (board_updated == query.board_mask);

    // ------------------------------
    // read path
    // ------------------------------
    assign hub_reg_raddr = (reg_raddr[15:12] == addr_hub) && (reg_raddr[11:2] == hub_reg_base);
    assign mem_rd        = (reg_raddr[15:12] == addr_hub) && (reg_raddr[11:9] == 3'd0);
    assign rd_sel        = hub_sel_e'(reg_raddr[1:0]);

    // hub registers read combinationally, list slot 0 in the top nibble
    always_comb begin
        reg_data = '0;
        case (rd_sel)
            sel_seq_mask: reg_data = {query.seq_num, query.board_mask};
            sel_index_lo: begin
                for (int i = 0; i < 8; i++) begin
                    reg_data[31 - 4*i -: 4] = read_list[i];
                end
            end
            sel_index_hi: begin
                for (int i = 0; i < 8; i++) begin
                    reg_data[31 - 4*i -: 4] = read_list[8 + i];
                end
            end
            default:      reg_data = {12'd0, board_id, query.board_mask_lower};
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (write_trig_reset) begin
            mem_rd_q <= 1'b0;
        end else begin
            mem_rd_q <= mem_rd;
        end
    end

    always_ff @(posedge sysclk) begin
        extra_q <= is_extra;
        first_q <= (mem_raddr[4:0] == 5'd0);
        board_q <= read_board;
    end

    // the first quadlet reports whether that board wrote since the query,
    // the extra quadlet reports the read start and the current time
    assign hub_data = extra_q ? {2'b00, bc_read_start, 2'b00, bc_timer}
                    : first_q ? {mem_rdata[31:16], board_updated[board_q], 1'b0, mem_rdata[13:0]}
                    : mem_rdata;

    // outside the hub space every read returns zero
    assign reg_rdata = hub_reg_raddr ? reg_data
                     : mem_rd_q      ? hub_data
                     : 32'd0;

endmodule

//--- tb.f
hdl/hub_pkg.sv
hdl/hub_mem.sv
hdl/hub_query_regs.sv
hdl/hub_read_xlate.sv
hdl/hub_bcast_trig.sv
hdl/hub_reg.sv
test/tb_clock.sv
test/tb_hub_reg.sv

//--- test/tb_clock.sv
`timescale 1ns/1ps
// ------------------------------
// testbench clock and reset
// 8 ns clock, reset held for the first 5 cycles or on request
// ------------------------------
module tb_clock #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 5
) (
    input  logic reset_req,
    output logic sysclk,
    output logic write_trig_reset
);

    logic por;

    initial begin
        sysclk = 1'b0;
    end

    always #(half_period) sysclk = ~sysclk;

    // power-on reset changes on the falling edge like the rest of the stimulus
    initial begin
        por = 1'b1;
        repeat (reset_cycles) @(negedge sysclk);
        por = 1'b0;
    end

    assign write_trig_reset = por | reset_req;

endmodule

//--- test/tb_hub_reg.sv
`timescale 1ns/1ps
// ------------------------------
// hub register block testbench
// checks the query registers, read list, update tracking, read
// translation and broadcast trigger against a reference model
// ------------------------------
module tb_hub_reg
    import hub_pkg::*;
;

    localparam int own_board   = 5;
    localparam int entry_quads = 29;
    // longest trigger wait, all five lower boards selected
    localparam int trig_cycles = slot_cycles * 5 + ack_cycles + 2;
    // peer writes take two cycles each, a sweep one cycle per quadlet
    localparam int entry_cycles = num_boards * entry_quads * 4 + 40;
    // one extra sweep right after the zero-mask query
    localparam int sweep_cycles = num_boards * entry_quads + 10;
    localparam int test_cycles  = 3 * (trig_cycles + 320) + 2 * entry_cycles
                                  + sweep_cycles + 100;
    localparam int watchdog_cycles = test_cycles + test_cycles / 5;

    logic        sysclk;
    logic        write_trig_reset;
    logic        reset_req;
    logic        reg_wen;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic [15:0] reg_raddr;
    logic [3:0]  board_id;
    logic [31:0] reg_rdata;
    logic [15:0] seq_num;
    logic [15:0] board_mask;
    logic        hub_reg_wen;
    logic        write_trig;
    logic        updated;

    // reference model of the query, the read list and the hub memory
    logic [15:0] model_seq;
    logic [15:0] model_mask;
    logic [3:0]  sel_boards [0:15];
    int          sel_count;
    logic [31:0] image [0:511];
    logic [31:0] rng;
    logic [15:0] mask_a;
    logic [15:0] mask_c;
    int          error_count;
    int          check_count;

    assign board_id = 4'(own_board);

    tb_clock tb_clock_inst (
        .reset_req        (reset_req),
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset)
    );

    hub_reg hub_reg_inst (
        .sysclk           (sysclk),
        .write_trig_reset (write_trig_reset),
        .reg_wen          (reg_wen),
        .reg_waddr        (reg_waddr),
        .reg_wdata        (reg_wdata),
        .reg_raddr        (reg_raddr),
        .board_id         (board_id),
        .reg_rdata        (reg_rdata),
        .seq_num          (seq_num),
        .board_mask       (board_mask),
        .hub_reg_wen      (hub_reg_wen),
        .write_trig       (write_trig),
        .updated          (updated)
    );

    // ------------------------------
    // checks and helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        check_count++;
        assert (cond) else begin
            error_count++;
            $display("ERROR time=%0t %s", $time, what);
        end
    endtask

    // 32-bit xorshift, one step per call
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // a zero mask leaves the previous mask and read list in place
    task automatic set_model_mask(input logic [15:0] mask);
        if (mask != 16'd0) begin
            model_mask = mask;
            sel_count  = 0;
            for (int b = 0; b < num_boards; b++) begin
                if (mask[b]) begin
                    sel_boards[sel_count] = 4'(b);
                    sel_count++;
                end
            end
        end
    endtask

    // eight list slots per register, the first slot in the top nibble
    function automatic logic [31:0] list_word(input int first);
        logic [31:0] word;
        word = '0;
        for (int j = 0; j < 8; j++) begin
            if (sel_count > 0) begin
                word[31 - 4*j -: 4] = sel_boards[(first + j) % sel_count];
            end
        end
        return word;
    endfunction

    // one slot per selected lower board, the acknowledge wait and two stages
    function automatic int trigger_delay(input logic [15:0] mask);
        int k;
        k = 0;
        for (int b = 0; b < own_board; b++) begin
            if (mask[b]) begin
                k++;
            end
        end
        return slot_cycles * k + ack_cycles + 2;
    endfunction

    task automatic write_quad(input logic [15:0] addr, input logic [31:0] data);
        @(negedge sysclk);
        reg_wen   = 1'b1;
        reg_waddr = addr;
        reg_wdata = data;
        // only a write to 0x1800 is a query
        #1;
        check_value("hub_reg_wen", {31'd0, addr == 16'h1800}, {31'd0, hub_reg_wen});
        @(negedge sysclk);
        reg_wen = 1'b0;
    endtask

    // returns on the falling edge right after the edge that took the query
    task automatic write_query(input logic [15:0] seq, input logic [15:0] mask);
        write_quad(16'h1800, {seq, mask});
        model_seq = seq;
        set_model_mask(mask);
    endtask

    task automatic read_hub(input logic [15:0] addr);
        @(negedge sysclk);
        reg_raddr = addr;
        #1;
    endtask

    task automatic check_query_regs();
        logic [15:0] lower;
        // only the selected boards numbered below this one
        lower = '0;
        for (int b = 0; b < own_board; b++) begin
            lower[b] = model_mask[b];
        end
        read_hub(16'h1800);
        check_value("reg_rdata[0x1800]", {model_seq, model_mask}, reg_rdata);
        read_hub(16'h1801);
        check_value("reg_rdata[0x1801]", list_word(0), reg_rdata);
        read_hub(16'h1802);
        check_value("reg_rdata[0x1802]", list_word(8), reg_rdata);
        read_hub(16'h1803);
        check_value("reg_rdata[0x1803]", {12'd0, 4'(own_board), lower}, reg_rdata);
        check_value("seq_num", {16'd0, model_seq}, {16'd0, seq_num});
        check_value("board_mask", {16'd0, model_mask}, {16'd0, board_mask});
    endtask

    // count falling edges from the query edge until write_trig is seen high
    task automatic watch_trigger(input bit expect_rise, input int delay);
        int first_high;
        int window;
        first_high = -1;
        window     = expect_rise ? delay + 20 : delay + 200;
        for (int cycle = 0; cycle <= window; cycle++) begin
            if (cycle > 0) begin
                @(negedge sysclk);
            end
            if (write_trig === 1'b1 && first_high < 0) begin
                first_high = cycle;
                if (expect_rise) begin
                    break;
                end
            end
        end
        if (!expect_rise) begin
            check_true("write_trig rose for a board outside the mask", first_high < 0);
        end else if (first_high < 0) begin
            check_true("write_trig never rose after the query", 1'b0);
        end else begin
            check_value("write_trig rise cycle", 32'(delay), 32'(first_high));
        end
    endtask

    task automatic hold_trigger(input int cycles);
        bit held;
        held = 1'b1;
        repeat (cycles) begin
            @(negedge sysclk);
            if (write_trig !== 1'b1) begin
                held = 1'b0;
            end
        end
        check_true("write_trig dropped before the next query", held);
    endtask

    // every selected board writes its whole entry, updated follows the last one
    task automatic write_entries();
        int addr;
        for (int e = 0; e < sel_count; e++) begin
            for (int q = 0; q < entry_quads; q++) begin
                rng  = xorshift32(rng);
                addr = 32 * int'(sel_boards[e]) + q;
                write_quad(16'h1000 + 16'(addr), rng);
                image[addr] = rng;
            end
            check_value("updated", {31'd0, e == sel_count - 1}, {31'd0, updated});
        end
    endtask

    // data for an address shows up one cycle after it, so check one behind
    task automatic check_sweep_data(input int addr, input int total, input bit upd);
        logic [31:0] img;
        string       name;
        name = $sformatf("reg_rdata[sweep 0x%0h]", addr);
        if (addr < total) begin
            img = image[32 * int'(sel_boards[addr / entry_quads]) + addr % entry_quads];
            if (addr % entry_quads == 0) begin
                // bit 15 tells whether the board wrote since the query,
                // bits 13:0 hold the write time
                check_value(name, {img[31:16], upd, 1'b0, 14'd0}, reg_rdata & 32'hffff_c000);
            end else begin
                check_value(name, img, reg_rdata);
            end
        end else begin
            check_value(name, 32'd0, reg_rdata & 32'hc000_c000);
        end
    endtask

    task automatic sweep_entries(input bit upd);
        int total;
        total = entry_quads * sel_count;
        for (int a = 0; a <= total + 1; a++) begin
            @(negedge sysclk);
            if (a > 0) begin
                check_sweep_data(a - 1, total, upd);
            end
            reg_raddr = (a <= total) ? 16'h1000 + 16'(a) : 16'h0000;
        end
    endtask

    task automatic apply_reset();
        @(negedge sysclk);
        reset_req = 1'b1;
        repeat (3) @(negedge sysclk);
        check_value("write_trig", 32'd0, {31'd0, write_trig});
        reset_req = 1'b0;
        @(negedge sysclk);
        model_seq  = '0;
        model_mask = '0;
        sel_count  = 0;
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        repeat (watchdog_cycles) @(posedge sysclk);
        $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("%0d checks, %0d errors", check_count, error_count);
        $display("Errors found");
        $finish;
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        reg_wen     = 1'b0;
        reg_waddr   = '0;
        reg_wdata   = '0;
        reg_raddr   = '0;
        reset_req   = 1'b0;
        rng         = 32'd54;
        error_count = 0;
        check_count = 0;
        model_seq   = '0;
        model_mask  = '0;
        sel_count   = 0;

        @(negedge sysclk);
        while (write_trig_reset) @(negedge sysclk);
        check_query_regs();
        check_value("updated", 32'd1, {31'd0, updated});
        check_value("write_trig", 32'd0, {31'd0, write_trig});

        // query with this board in the mask
        rng    = xorshift32(rng);
        mask_a = rng[15:0] | 16'h0020;
        write_query(rng[31:16], mask_a);
        check_value("updated", 32'd0, {31'd0, updated});
        watch_trigger(1'b1, trigger_delay(mask_a));
        // also gives the read list builder its 300 cycles
        hold_trigger(300);
        check_query_regs();
        write_entries();
        sweep_entries(1'b1);
        sweep_entries(1'b1);
        check_value("write_trig", 32'd1, {31'd0, write_trig});

        // a zero mask only moves the sequence number
        write_query(model_seq + 16'd1, 16'd0);
        check_value("write_trig", 32'd0, {31'd0, write_trig});
        check_value("updated", 32'd0, {31'd0, updated});
        check_query_regs();
        // the entries are still there, but no board has written since the query
        sweep_entries(1'b0);

        // query without this board, the trigger has to stay low
        rng    = xorshift32(rng);
        mask_c = rng[15:0] & 16'hffdf;
        if (mask_c == 16'd0) begin
            mask_c = 16'h0100;
        end
        write_query(rng[31:16], mask_c);
        check_value("updated", 32'd0, {31'd0, updated});
        watch_trigger(1'b0, trigger_delay(mask_c));
        check_query_regs();
        write_entries();
        sweep_entries(1'b1);
        sweep_entries(1'b1);

        // raise the trigger once more and drop it with the reset
        write_query(model_seq + 16'd7, mask_a);
        watch_trigger(1'b1, trigger_delay(mask_a));
        apply_reset();
        check_value("write_trig", 32'd0, {31'd0, write_trig});
        check_value("updated", 32'd1, {31'd0, updated});
        check_query_regs();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
